// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_decode_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  fetch_valid_i,
    output logic                       fetch_ready_o,
    input  fetch_pkt_t                 fetch_i,
    output logic                       dec_valid_o,
    input  wire logic                  dec_ready_i,
    output decoded_pkt_t               dec_o,
    input  wire logic                  wb_wen_i,
    input  wire logic [REG_ADDR_W-1:0] wb_addr_i,
    input  wire logic [XLEN-1:0]       wb_data_i
);

    fetch_pkt_t            fetch_q;
    logic                  fetch_q_valid;
    logic                  fetch_q_ready;
    imm_set_t              imms;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    decoded_pkt_t          dec_d;

    // registered fetch packet, decoded out of this register
    pipe_stage #(.payload_t(fetch_pkt_t)) u_fetch_stage (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (fetch_valid_i),
        .in_ready_o  (fetch_ready_o),
        .in_data_i   (fetch_i),
        .out_valid_o (fetch_q_valid),
        .out_ready_i (fetch_q_ready),
        .out_data_o  (fetch_q)
    );

    imm_gen u_imm_gen (
        .inst_i (fetch_q.inst),
        .imms_o (imms)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wen_i      (wb_wen_i),
        .waddr_i    (wb_addr_i),
        .wdata_i    (wb_data_i)
    );

    inst_decoder u_inst_decoder (
        .fetch_i    (fetch_q),
        .imms_i     (imms),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .dec_o      (dec_d)
    );

    // decoded packet register toward execute
    pipe_stage #(.payload_t(decoded_pkt_t)) u_dec_stage (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (fetch_q_valid),
        .in_ready_o  (fetch_q_ready),
        .in_data_i   (dec_d),
        .out_valid_o (dec_valid_o),
        .out_ready_i (dec_ready_i),
        .out_data_o  (dec_o)
    );

endmodule

`default_nettype wire

// File: rtl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen import rv_decode_pkg::*; (
    input  wire logic [ILEN-1:0] inst_i,
    output imm_set_t             imms_o
);

    logic sgn;

    assign sgn = inst_i[31];    // every format sign-extends from bit 31

    // i-type, also loads and jalr
    assign imms_o.imm_i = {{(XLEN-12){sgn}}, inst_i[31:20]};

    // s-type, split around rd field
    assign imms_o.imm_s = {{(XLEN-12){sgn}}, inst_i[31:25], inst_i[11:7]};

    // b-type, bit 0 always zero
    assign imms_o.imm_b = {{(XLEN-13){sgn}}, sgn, inst_i[7], inst_i[30:25],
                           inst_i[11:8], 1'b0};

    // u-type, sign-extended above bit 31 as rv64 wants
    assign imms_o.imm_u = {{(XLEN-ILEN){sgn}}, inst_i[31:12], 12'b0};

    // j-type
    assign imms_o.imm_j = {{(XLEN-21){sgn}}, sgn, inst_i[19:12], inst_i[20],
                           inst_i[30:21], 1'b0};

    assign imms_o.shamt = inst_i[25:20];    // 6 bits for 64-bit shifts

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import rv_decode_pkg::*; (
    input  fetch_pkt_t                  fetch_i,
    input  imm_set_t                    imms_i,
    output logic [REG_ADDR_W-1:0]       rs1_addr_o,
    output logic [REG_ADDR_W-1:0]       rs2_addr_o,
    input  wire logic [XLEN-1:0]        rs1_data_i,
    input  wire logic [XLEN-1:0]        rs2_data_i,
    output decoded_pkt_t                dec_o
);

    logic [6:0]            opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [6:0]            funct7;
    logic [XLEN-1:0]       shamt_ext;
    logic [XLEN-1:0]       rs2_shamt;
    logic                  inst_ok;    // encoding belongs to a kept group
    logic                  use_rs1;
    logic                  use_rs2;

    assign opcode = fetch_i.inst[6:0];
    assign rd     = fetch_i.inst[11:7];
    assign funct3 = fetch_i.inst[14:12];
    assign rs1    = fetch_i.inst[19:15];
    assign rs2    = fetch_i.inst[24:20];
    assign funct7 = fetch_i.inst[31:25];

    assign shamt_ext = {{(XLEN-SHAMT_W){1'b0}}, imms_i.shamt};
    assign rs2_shamt = {{(XLEN-SHAMT_W){1'b0}}, rs2_data_i[SHAMT_W-1:0]};

    // validity and source usage depend on the encoding only,
    // kept apart from the operand mux so there is no false loop via reg_file
    always_comb begin
        inst_ok = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                inst_ok = 1'b1;
                use_rs1 = 1'b1;
            end
            OPC_OP_IMM_32: begin
                inst_ok = funct3 inside {3'b000, F3_SLL, F3_SR};    // addiw/slliw/sr*iw
                use_rs1 = inst_ok;
            end
            OPC_OP: begin
                inst_ok = 1'b1;    // all eight funct3 used, m ext included
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_OP_32: begin
                inst_ok = funct3 inside {3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
                use_rs1 = inst_ok;
                use_rs2 = inst_ok;
            end
            OPC_BRANCH: begin
                inst_ok = !(funct3 inside {F3_BR_RSV0, F3_BR_RSV1});
                use_rs1 = inst_ok;
                use_rs2 = inst_ok;
            end
            OPC_LOAD: begin
                inst_ok = (funct3 != F3_LOAD_INVALID);
                use_rs1 = inst_ok;
            end
            OPC_STORE: begin
                inst_ok = (funct3[2] == 1'b0);    // sb/sh/sw/sd
                use_rs1 = inst_ok;
                use_rs2 = inst_ok;
            end
            OPC_JALR: begin
                inst_ok = 1'b1;
                use_rs1 = 1'b1;
            end
            OPC_JAL, OPC_LUI, OPC_AUIPC: begin
                inst_ok = 1'b1;
            end
            default: begin
                inst_ok = 1'b0;
            end
        endcase
    end

    assign rs1_addr_o = use_rs1 ? rs1 : '0;
    assign rs2_addr_o = use_rs2 ? rs2 : '0;

    // operands and address pair; untouched fields stay zero
    always_comb begin
        dec_o           = '0;
        dec_o.inst      = fetch_i.inst;
        dec_o.inst_addr = fetch_i.inst_addr;
        if (inst_ok) begin
            case (opcode)
                OPC_OP_IMM, OPC_OP_IMM_32: begin
                    dec_o.op1 = rs1_data_i;
                    dec_o.op2 = (funct3 inside {F3_SLL, F3_SR}) ? shamt_ext : imms_i.imm_i;
                    dec_o.rd_addr = rd;
                    dec_o.rd_wen  = 1'b1;
                end
                OPC_OP: begin
                    dec_o.op1 = rs1_data_i;
                    // shifts only see the low 6 bits, divu keeps the full value
                    if (funct3 == F3_SLL || (funct3 == F3_SR && funct7 != F7_MULDIV)) begin
                        dec_o.op2 = rs2_shamt;
                    end else begin
                        dec_o.op2 = rs2_data_i;
                    end
                    dec_o.rd_addr = rd;
                    dec_o.rd_wen  = 1'b1;
                end
                OPC_OP_32: begin
                    dec_o.op1     = rs1_data_i;
                    dec_o.op2     = rs2_data_i;
                    dec_o.rd_addr = rd;
                    dec_o.rd_wen  = 1'b1;
                end
                OPC_BRANCH: begin
                    dec_o.op1         = rs1_data_i;    // compared in execute
                    dec_o.op2         = rs2_data_i;
                    dec_o.base_addr   = fetch_i.inst_addr;
                    dec_o.offset_addr = imms_i.imm_b;
                end
                OPC_LOAD: begin
                    dec_o.op1         = rs1_data_i;
                    dec_o.op2         = imms_i.imm_i;
                    dec_o.rd_addr     = rd;
                    dec_o.rd_wen      = 1'b1;
                    dec_o.base_addr   = rs1_data_i;
                    dec_o.offset_addr = imms_i.imm_i;
                end
                OPC_STORE: begin
                    dec_o.op2         = rs2_data_i;    // store data
                    dec_o.base_addr   = rs1_data_i;
                    dec_o.offset_addr = imms_i.imm_s;
                end
                OPC_JAL, OPC_JALR: begin
                    dec_o.op1     = fetch_i.inst_addr;    // link = pc + 4
                    dec_o.op2     = INST_BYTES;
                    dec_o.rd_addr = rd;
                    dec_o.rd_wen  = 1'b1;
                    if (opcode == OPC_JALR) begin
                        dec_o.base_addr   = rs1_data_i;
                        dec_o.offset_addr = imms_i.imm_i;
                    end else begin
                        dec_o.base_addr   = fetch_i.inst_addr;
                        dec_o.offset_addr = imms_i.imm_j;
                    end
                end
                OPC_LUI: begin
                    dec_o.op2     = imms_i.imm_u;
                    dec_o.rd_addr = rd;
                    dec_o.rd_wen  = 1'b1;
                end
                OPC_AUIPC: begin
                    dec_o.op1         = fetch_i.inst_addr;
                    dec_o.op2         = imms_i.imm_u;
                    dec_o.rd_addr     = rd;
                    dec_o.rd_wen      = 1'b1;
                    dec_o.offset_addr = imms_i.imm_u;
                end
                default: begin
                    dec_o.rd_wen = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/pipe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire logic in_valid_i,
    output logic      in_ready_o,
    input  payload_t  in_data_i,
    output logic      out_valid_o,
    input  wire logic out_ready_i,
    output payload_t  out_data_o
);

    logic     full_q;
    payload_t data_q;

    // take a new item when empty or when the current one leaves this cycle
    assign in_ready_o = !full_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (in_ready_o) begin
            full_q <= in_valid_i;    // drains to empty when nothing arrives
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_decode_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  wire logic [REG_ADDR_W-1:0] rs2_addr_i,
    output logic      [XLEN-1:0]       rs1_data_o,
    output logic      [XLEN-1:0]       rs2_data_o,
    input  wire logic                  wen_i,
    input  wire logic [REG_ADDR_W-1:0] waddr_i,
    input  wire logic [XLEN-1:0]       wdata_i
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // one write port, x0 never written
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // no bypass, a same-cycle write is seen next cycle
    always_comb begin
        if (rs1_addr_i == '0) begin
            rs1_data_o = '0;
        end else begin
            rs1_data_o = regs[rs1_addr_i];
        end
    end

    always_comb begin
        if (rs2_addr_i == '0) begin
            rs2_data_o = '0;
        end else begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 6;    // rv64 shift amount

    // link value for jal/jalr, pc of the next instruction
    localparam logic [XLEN-1:0] INST_BYTES = 'd4;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

    // funct3 codes the decoder looks at
    localparam logic [2:0] F3_SLL          = 3'b001;
    localparam logic [2:0] F3_SR           = 3'b101;   // srl/sra, also divu
    localparam logic [2:0] F3_LOAD_INVALID = 3'b111;   // no such load
    localparam logic [2:0] F3_BR_RSV0      = 3'b010;
    localparam logic [2:0] F3_BR_RSV1      = 3'b011;

    // funct7 codes
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;    // sra, sub
    localparam logic [6:0] F7_MULDIV = 7'b0000001;    // m extension

    // fetched instruction with its pc
    typedef struct packed {
        logic [ILEN-1:0] inst;
        logic [XLEN-1:0] inst_addr;
    } fetch_pkt_t;

    // what execute gets from decode
    typedef struct packed {
        logic [ILEN-1:0]       inst;
        logic [XLEN-1:0]       inst_addr;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rd_wen;
        logic [XLEN-1:0]       base_addr;    // branch/jump/mem address base
        logic [XLEN-1:0]       offset_addr;  // added to base_addr
    } decoded_pkt_t;

    // every immediate format of one instruction
    typedef struct packed {
        logic [XLEN-1:0]    imm_i;
        logic [XLEN-1:0]    imm_s;
        logic [XLEN-1:0]    imm_b;
        logic [XLEN-1:0]    imm_u;
        logic [XLEN-1:0]    imm_j;
        logic [SHAMT_W-1:0] shamt;
    } imm_set_t;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_decode_stage -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "All checks passed" sim.log || { echo "no pass result in log"; exit 1; }
exit 0

// File: sim/decode_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module decode_asserts #(
    parameter type payload_t = logic
) (
    input wire logic     clk,
    input wire logic     reset_i,
    input wire logic     in_valid_i,
    input wire payload_t in_data_i,
    input wire logic     out_valid_o,
    input wire logic     out_ready_i,
    input wire payload_t out_data_o
);

    // stage comes out of reset empty
    a_reset_empty: assert property (@(posedge clk) reset_i |=> !out_valid_o)
        else $error("out_valid_o high in the cycle after reset");

    // a stalled item may not change or vanish
    a_hold_stable: assert property (@(posedge clk) disable iff (reset_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)))
        else $error("stalled output changed before transfer");

    // an empty stage takes what is offered and shows it next cycle
    a_empty_takes: assert property (@(posedge clk) disable iff (reset_i)
        (!out_valid_o && in_valid_i) |=> (out_valid_o && out_data_o == $past(in_data_i)))
        else $error("empty stage did not take the offered item");

endmodule

bind pipe_stage decode_asserts #(.payload_t(payload_t)) u_asserts (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
);

`default_nettype wire

// File: sim/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import rv_decode_pkg::*; ();

    logic                  clk = 1'b0;
    logic                  reset_i;
    logic                  fetch_valid_i;
    logic                  fetch_ready_o;
    fetch_pkt_t            fetch_i;
    logic                  dec_valid_o;
    logic                  dec_ready_i = 1'b0;
    decoded_pkt_t          dec_o;
    logic                  wb_wen_i;
    logic [REG_ADDR_W-1:0] wb_addr_i;
    logic [XLEN-1:0]       wb_data_i;

    integer          seed = 32'hff41_bbec;
    logic [XLEN-1:0] model [NUM_REGS];
    decoded_pkt_t    exp_q [$];
    int              errors = 0;
    int              n_checks = 0;
    int              cyc = 0;
    int              accept_cyc = 0;
    int              out_cyc = 0;
    logic            rand_ready = 1'b0;

    decode_stage uut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // execute side ready toggles randomly or stays high
    always @(posedge clk) begin
        logic [31:0] r;
        #0.5;
        r = $random(seed);
        dec_ready_i = rand_ready ? r[0] : 1'b1;
    end

    function automatic logic [XLEN-1:0] reg_val(input logic [4:0] idx);
        return (idx == 5'd0) ? '0 : model[idx];
    endfunction

    function automatic decoded_pkt_t ref_decode(input fetch_pkt_t f);
        decoded_pkt_t d;
        logic [31:0]  x;
        logic [2:0]   f3;
        logic [63:0]  a, b, ii, is, ib, iu, ij;
        logic         wr;
        x  = f.inst;
        f3 = x[14:12];
        a  = reg_val(x[19:15]);
        b  = reg_val(x[24:20]);
        ii = {{52{x[31]}}, x[31:20]};
        is = {{52{x[31]}}, x[31:25], x[11:7]};
        ib = {{51{x[31]}}, x[31], x[7], x[30:25], x[11:8], 1'b0};
        iu = {{32{x[31]}}, x[31:12], 12'h000};
        ij = {{43{x[31]}}, x[31], x[19:12], x[20], x[30:21], 1'b0};
        wr = 1'b0;
        d  = '0;
        d.inst = x;
        d.inst_addr = f.inst_addr;
        case (x[6:0])
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                if (x[6:0] == OPC_OP_IMM || f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101) begin
                    d.op1 = a;
                    d.op2 = (f3 == 3'b001 || f3 == 3'b101) ? {58'd0, x[25:20]} : ii;
                    wr = 1'b1;
                end
            end
            OPC_OP: begin
                d.op1 = a;
                d.op2 = (f3 == 3'b001 || (f3 == 3'b101 && x[31:25] != 7'b0000001)) ?
                        {58'd0, b[5:0]} : b;
                wr = 1'b1;
            end
            OPC_OP_32, OPC_BRANCH: begin
                if (f3 != 3'b010 && f3 != 3'b011) begin
                    d.op1 = a;
                    d.op2 = b;
                    wr = (x[6:0] == OPC_OP_32);
                    if (!wr) begin
                        d.base_addr   = f.inst_addr;
                        d.offset_addr = ib;
                    end
                end
            end
            OPC_LOAD: if (f3 != 3'b111) begin
                d.op1 = a;
                d.op2 = ii;
                d.base_addr = a;
                d.offset_addr = ii;
                wr = 1'b1;
            end
            OPC_STORE: if (!f3[2]) begin
                d.op2 = b;
                d.base_addr = a;
                d.offset_addr = is;
            end
            OPC_JAL, OPC_JALR: begin
                d.op1 = f.inst_addr;
                d.op2 = 64'd4;
                d.base_addr = (x[6:0] == OPC_JAL) ? f.inst_addr : a;
                d.offset_addr = (x[6:0] == OPC_JAL) ? ij : ii;
                wr = 1'b1;
            end
            OPC_LUI: begin
                d.op2 = iu;
                wr = 1'b1;
            end
            OPC_AUIPC: begin
                d.op1 = f.inst_addr;
                d.op2 = iu;
                d.offset_addr = iu;
                wr = 1'b1;
            end
            default: d.rd_wen = 1'b0;    // unknown opcode
        endcase
        if (wr) begin
            d.rd_wen  = 1'b1;
            d.rd_addr = x[11:7];
        end
        return d;
    endfunction

    task automatic check_field(input string name, input logic [63:0] e, input logic [63:0] a);
        n_checks++;
        assert (e === a) else begin
            $display("ERR %s expected %h actual %h", name, e, a);
            errors++;
        end
    endtask

    // scoreboard pops one entry per output transfer
    always @(posedge clk) begin
        decoded_pkt_t e;
        if (!reset_i && dec_valid_o && dec_ready_i) begin
            out_cyc = cyc;
            if (exp_q.size() == 0) begin
                $display("output transfer with no instruction outstanding");
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_field("inst", 64'(e.inst), 64'(dec_o.inst));
                check_field("inst_addr", e.inst_addr, dec_o.inst_addr);
                check_field("op1", e.op1, dec_o.op1);
                check_field("op2", e.op2, dec_o.op2);
                check_field("rd_addr", 64'(e.rd_addr), 64'(dec_o.rd_addr));
                check_field("rd_wen", 64'(e.rd_wen), 64'(dec_o.rd_wen));
                check_field("base_addr", e.base_addr, dec_o.base_addr);
                check_field("offset_addr", e.offset_addr, dec_o.offset_addr);
            end
        end
    end

    task automatic end_run();
        $display("checks %0d, errors %0d", n_checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    function automatic logic [31:0] mk_inst(input logic [6:0] opc, input logic [2:0] f3,
                                            input logic [6:0] f7);
        logic [31:0] x;
        x = $random(seed);
        x[6:0]   = opc;
        x[14:12] = f3;
        if (opc == OPC_OP || opc == OPC_OP_32) begin
            x[31:25] = f7;    // only r-type fixes funct7
        end
        return x;
    endfunction

    task automatic send(input logic [31:0] inst);
        fetch_pkt_t f;
        int         t;
        logic       acc;
        f.inst = inst;
        f.inst_addr = {$random(seed), $random(seed)} & ~64'h3;
        exp_q.push_back(ref_decode(f));
        fetch_i = f;
        fetch_valid_i = 1'b1;
        acc = 1'b0;
        t = 0;
        while (!acc && t < 200) begin
            @(posedge clk);
            acc = fetch_ready_o;
            t++;
        end
        accept_cyc = cyc;
        #0.5;
        fetch_valid_i = 1'b0;
        if (!acc) begin
            $display("timeout: fetch never accepted");
            errors++;
            end_run();
        end
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 5000) begin
            @(posedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d decoded packets never came out", exp_q.size());
            errors++;
            end_run();
        end
        repeat (2) @(posedge clk);
        #0.5;
    endtask

    task automatic wb_write(input logic [4:0] addr, input logic [63:0] data);
        wb_wen_i  = 1'b1;
        wb_addr_i = addr;
        wb_data_i = data;
        @(posedge clk);
        #0.5;
        wb_wen_i = 1'b0;
        if (addr != 5'd0) begin
            model[addr] = data;
        end
    endtask

    task automatic report(input string name, input int err0);
        $display("test %s: %s, %0d errors", name, (errors == err0) ? "ok" : "mismatch",
                 errors - err0);
    endtask

    initial begin
        int          e0;
        logic [6:0]  opcs [11];
        logic [31:0] r;
        opcs = '{OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32, OPC_BRANCH, OPC_LOAD,
                 OPC_STORE, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC};
        reset_i = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_i = '0;
        wb_wen_i = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        for (int i = 0; i < NUM_REGS; i++) model[i] = '0;
        repeat (10) @(posedge clk);
        #0.5;
        reset_i = 1'b0;

        e0 = errors;
        check_field("dec_valid_o", 64'd0, 64'(dec_valid_o));
        check_field("fetch_ready_o", 64'd1, 64'(fetch_ready_o));
        for (int i = 1; i < NUM_REGS; i++) wb_write(5'(i), {$random(seed), $random(seed)});
        foreach (opcs[k]) begin
            for (int j = 0; j < 3; j++) begin
                // 010 is reserved in op-imm-32, op-32 and branch
                send(mk_inst(opcs[k], (k == 1 || k == 3 || k == 4) ? 3'b000 : 3'b010,
                             F7_BASE));
            end
        end
        drain();
        report("1 reset and groups", e0);

        e0 = errors;
        send(mk_inst(OPC_OP_IMM, F3_SLL, F7_BASE));
        send(mk_inst(OPC_OP_IMM, F3_SR, F7_ALT));
        send(mk_inst(OPC_OP_IMM_32, F3_SR, F7_BASE));
        send(mk_inst(OPC_OP, F3_SLL, F7_BASE));
        send(mk_inst(OPC_OP, F3_SR, F7_BASE));
        send(mk_inst(OPC_OP, F3_SR, F7_ALT));
        send(mk_inst(OPC_OP, F3_SR, F7_MULDIV));
        drain();
        report("2 shifts", e0);

        e0 = errors;
        for (int f = 2; f < 8; f++) begin
            if (f != 5) send(mk_inst(OPC_OP_IMM_32, 3'(f), F7_BASE));
        end
        send(mk_inst(OPC_OP_32, 3'b010, F7_BASE));
        send(mk_inst(OPC_OP_32, 3'b011, F7_BASE));
        send(mk_inst(OPC_BRANCH, F3_BR_RSV0, F7_BASE));
        send(mk_inst(OPC_BRANCH, F3_BR_RSV1, F7_BASE));
        send(mk_inst(OPC_LOAD, F3_LOAD_INVALID, F7_BASE));
        for (int f = 4; f < 8; f++) send(mk_inst(OPC_STORE, 3'(f), F7_BASE));
        send(mk_inst(7'b1110011, 3'b000, F7_BASE));    // system
        send(mk_inst(7'b0001111, 3'b000, F7_BASE));    // fence
        send(mk_inst(7'b1111111, 3'b111, F7_BASE));
        drain();
        report("3 invalid encodings", e0);

        e0 = errors;
        wb_write(5'd0, 64'hdead_beef_cafe_f00d);
        r = mk_inst(OPC_OP, 3'b000, F7_BASE);
        r[24:15] = 10'd0;    // rs1 = rs2 = x0
        send(r);
        r = mk_inst(OPC_STORE, 3'b011, F7_BASE);
        r[24:15] = 10'd0;
        send(r);
        drain();
        report("4 x0", e0);

        e0 = errors;
        send(mk_inst(OPC_OP, 3'b000, F7_BASE));
        drain();
        check_field("latency", 64'd2, 64'(out_cyc - accept_cyc));
        rand_ready = 1'b1;
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            send(mk_inst(opcs[r[7:0] % 11], r[10:8], r[11] ? F7_MULDIV : F7_ALT));
        end
        drain();
        rand_ready = 1'b0;
        report("5 random stream", e0);

        end_run();
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/rv_decode_pkg.sv
rtl/imm_gen.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/pipe_stage.sv
rtl/decode_stage.sv
sim/decode_asserts.sv
sim/tb_decode_stage.sv
